//--- Makefile
# Verilator build and run of the trace monitor testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := trace_monitor_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/inst_capture.sv
/*
 * Instruction capture
 * Follows one of two cores, holds opcode, interrupt info and PC on
 * each decode strobe, and counts instructions and cycles per instruction
 */

`timescale 1ns/1ps
`default_nettype none

module inst_capture
  import trace_pkg::*;
#(
  parameter int CNT_W = 32  // Counter width
) (
  input  wire              mclk,
  input  wire              puc_rst,
  input  wire core_trace_t i_core0,
  input  wire core_trace_t i_core1,
  input  wire              i_core_select,  // High follows core 1
  output held_inst_t       o_held,
  output logic [15:0]      o_inst_pc,
  output logic [CNT_W-1:0] o_inst_number,  // Decodes since reset
  output logic [CNT_W-1:0] o_inst_cycle,   // Edges since last decode
  output logic [2:0]       o_fetch_bin,
  output logic [3:0]       o_exec_bin
);

  core_trace_t sel;  // Trace of the followed core

  // ================================================
  // Core selection
  // ================================================
  assign sel = i_core_select ? i_core1 : i_core0;

  assign o_fetch_bin = sel.fetch_bin;  // Straight to state decode
  assign o_exec_bin  = sel.exec_bin;

  // ================================================
  // Capture on decode
  // ================================================
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      // Reads as RESET entry until first decode
      o_held    <= '{opcode: '0, irq: 1'b1, irq_num: '1};
      o_inst_pc <= '0;
    end else if (sel.decode) begin
      o_held    <= '{opcode: sel.ir, irq: sel.irq_detect, irq_num: sel.irq_num};
      o_inst_pc <= sel.pc;
    end
  end

  // Instruction count
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_inst_number <= '0;
    end else if (sel.decode) begin
      o_inst_number <= o_inst_number + 1'b1;
    end
  end

  // Cycle within instruction
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      o_inst_cycle <= '0;
    end else if (sel.decode) begin
      o_inst_cycle <= '0;                   // Restart on every strobe
    end else begin
      o_inst_cycle <= o_inst_cycle + 1'b1;  // Free-running, wraps
    end
  end

  // ================================================
  // Checks
  // ================================================
  // Strobe from the followed core must be clean once out of reset
  a_decode_known: assert property (
    @(posedge mclk) disable iff (puc_rst) !$isunknown(sel.decode)
  ) else $error("decode strobe unknown");

  // Back-to-back strobes keep the count at zero
  a_cycle_restart: assert property (
    @(posedge mclk) disable iff (puc_rst) sel.decode |=> (o_inst_cycle == '0)
  ) else $error("cycle counter not cleared by decode");

endmodule

`default_nettype wire

//--- design/inst_classify.sv
/*
 * Instruction classifier
 * Format and mnemonic of the held instruction, or the interrupt
 * source when the entry was an interrupt
 */

`timescale 1ns/1ps
`default_nettype none

module inst_classify
  import msp430_isa_pkg::*, trace_pkg::*;
(
  input  wire held_inst_t i_held,
  output inst_class_e     o_class,
  output mnemonic_e       o_mnemonic
);

  logic [2:0] fmt;  // Format bits 15:13
  assign fmt = i_held.opcode[OPCODE_W-1:OP_CLASS_LSB];

  // Format
  always_comb begin
    if (i_held.irq) begin
      o_class = IC_IRQ;
    end else begin
      case (fmt)
        3'b000:  o_class = IC_SINGLE;
        3'b001:  o_class = IC_JUMP;
        default: o_class = IC_TWO_OP;  // 010..111
      endcase
    end
  end

  // ================================================
  // Mnemonic tables
  // ================================================
  always_comb begin
    o_mnemonic = MN_INVALID;
    case (o_class)
      IC_IRQ: begin
        case (i_held.irq_num)
          4'd14:   o_mnemonic = MN_NMI;
          4'd15:   o_mnemonic = MN_RESET;
          default: o_mnemonic = MN_IRQ;  // Number kept in record
        endcase
      end
      IC_SINGLE: begin
        case (i_held.opcode[15:7])
          9'b000100_000: o_mnemonic = MN_RRC;
          9'b000100_001: o_mnemonic = MN_SWPB;
          9'b000100_010: o_mnemonic = MN_RRA;
          9'b000100_011: o_mnemonic = MN_SXT;
          9'b000100_100: o_mnemonic = MN_PUSH;
          9'b000100_101: o_mnemonic = MN_CALL;
          9'b000100_110: o_mnemonic = MN_RETI;
          default:       o_mnemonic = MN_INVALID;  // Unused format II slots
        endcase
      end
      IC_JUMP: begin
        case (i_held.opcode[15:10])  // Condition in 12:10
          6'b001_000: o_mnemonic = MN_JNE;
          6'b001_001: o_mnemonic = MN_JEQ;
          6'b001_010: o_mnemonic = MN_JNC;
          6'b001_011: o_mnemonic = MN_JC;
          6'b001_100: o_mnemonic = MN_JN;
          6'b001_101: o_mnemonic = MN_JGE;
          6'b001_110: o_mnemonic = MN_JL;
          default:    o_mnemonic = MN_JMP;  // 001_111
        endcase
      end
      default: begin
        case (i_held.opcode[15:12])
          4'b0100: o_mnemonic = MN_MOV;
          4'b0101: o_mnemonic = MN_ADD;
          4'b0110: o_mnemonic = MN_ADDC;
          4'b0111: o_mnemonic = MN_SUBC;
          4'b1000: o_mnemonic = MN_SUB;
          4'b1001: o_mnemonic = MN_CMP;
          4'b1010: o_mnemonic = MN_DADD;
          4'b1011: o_mnemonic = MN_BIT;
          4'b1100: o_mnemonic = MN_BIC;
          4'b1101: o_mnemonic = MN_BIS;
          4'b1110: o_mnemonic = MN_XOR;
          4'b1111: o_mnemonic = MN_AND;
          default: o_mnemonic = MN_INVALID;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/msp430_isa_pkg.sv
/*
 * MSP430 instruction set definitions
 * Opcode field positions, register numbers, special opcodes and the
 * enumerations used to report a decoded instruction
 */

`default_nettype none

package msp430_isa_pkg;

  // ================================================
  // Widths
  // ================================================
  localparam int OPCODE_W  = 16;  // Instruction word
  localparam int REG_IDX_W = 4;   // r0..r15
  localparam int IRQ_NUM_W = 4;   // IRQ 0..13, NMI, RESET

  // ================================================
  // Opcode field positions
  // ================================================
  localparam int OP_CLASS_LSB = 13;  // Bits 15:13 select the format
  localparam int OP_SRC_LSB   = 8;   // Two-op source register
  localparam int OP_AD_BIT    = 7;   // Destination mode
  localparam int OP_BW_BIT    = 6;   // Byte/word select
  localparam int OP_AS_LSB    = 4;   // Source mode, 2 bits
  localparam int OP_DST_LSB   = 0;   // Dest reg, also single-op reg

  // Registers with special addressing behaviour
  localparam logic [REG_IDX_W-1:0] REG_PC = 4'd0;  // Program counter
  localparam logic [REG_IDX_W-1:0] REG_SR = 4'd2;  // Status reg / CG1
  localparam logic [REG_IDX_W-1:0] REG_CG = 4'd3;  // Constant generator

  // Special opcodes
  localparam logic [OPCODE_W-1:0] NOP_OPCODE   = 16'h4303;  // MOV #0, r3
  localparam logic [OPCODE_W-1:0] SWBRK_OPCODE = 16'h4343;  // MOV.B #0, r3

  // ================================================
  // Instruction enumerations
  // ================================================
  typedef enum logic [1:0] {
    IC_IRQ,     // Interrupt entry
    IC_SINGLE,  // Format II
    IC_JUMP,    // Format III
    IC_TWO_OP   // Format I
  } inst_class_e;

  typedef enum logic [4:0] {
    MN_IRQ, MN_NMI, MN_RESET,
    // Single-operand
    MN_RRC, MN_SWPB, MN_RRA, MN_SXT, MN_PUSH, MN_CALL, MN_RETI,
    // Jumps
    MN_JNE, MN_JEQ, MN_JNC, MN_JC, MN_JN, MN_JGE, MN_JL, MN_JMP,
    // Two-operand
    MN_MOV, MN_ADD, MN_ADDC, MN_SUBC, MN_SUB, MN_CMP,
    MN_DADD, MN_BIT, MN_BIC, MN_BIS, MN_XOR, MN_AND,
    MN_INVALID  // No table entry
  } mnemonic_e;

  typedef enum logic [3:0] {
    SM_NONE,
    SM_REG,        // Rn
    SM_INDEXED,    // x(Rn)
    SM_SYMBOLIC,   // EDE, PC relative
    SM_ABSOLUTE,   // &EDE
    SM_INDIRECT,   // @Rn
    SM_AUTOINC,    // @Rn+
    SM_IMMEDIATE,  // #N
    SM_CONST_0, SM_CONST_1, SM_CONST_2, SM_CONST_M1,  // From r3
    SM_CONST_4, SM_CONST_8                            // From r2
  } src_mode_e;

  typedef enum logic [2:0] {
    DM_NONE, DM_REG, DM_INDEXED, DM_SYMBOLIC, DM_ABSOLUTE
  } dst_mode_e;

  typedef enum logic [1:0] {
    SP_NONE, SP_NOP, SP_SBREAK
  } special_e;

endpackage

`default_nettype wire

//--- design/operand_decode.sv
/*
 * Operand decoder
 * Byte flag, source and destination registers with their addressing
 * modes (constant generator included), and NOP / software break
 */

`timescale 1ns/1ps
`default_nettype none

module operand_decode
  import msp430_isa_pkg::*, trace_pkg::*;
(
  input  wire held_inst_t            i_held,
  input  wire inst_class_e           i_class,
  output logic                       o_byte,
  output logic       [REG_IDX_W-1:0] o_src_reg,
  output src_mode_e                  o_src_mode,
  output logic       [REG_IDX_W-1:0] o_dst_reg,
  output dst_mode_e                  o_dst_mode,
  output special_e                   o_special
);

  logic [OPCODE_W-1:0]  op;
  logic [REG_IDX_W-1:0] lo_reg;   // Bits 3:0
  logic [REG_IDX_W-1:0] hi_reg;   // Bits 11:8
  logic [1:0]           as_bits;

  assign op      = i_held.opcode;
  assign lo_reg  = op[OP_DST_LSB +: REG_IDX_W];
  assign hi_reg  = op[OP_SRC_LSB +: REG_IDX_W];
  assign as_bits = op[OP_AS_LSB +: 2];

  // As applied to a register, r2/r3 double as constant generators
  function automatic src_mode_e src_mode_f(input logic [1:0] as_f,
                                           input logic [REG_IDX_W-1:0] rg);
    src_mode_e m;
    if (rg == REG_CG) begin
      case (as_f)
        2'b00:   m = SM_CONST_0;
        2'b01:   m = SM_CONST_1;
        2'b10:   m = SM_CONST_2;
        default: m = SM_CONST_M1;
      endcase
    end else if (rg == REG_SR) begin
      case (as_f)
        2'b00:   m = SM_REG;
        2'b01:   m = SM_ABSOLUTE;  // &EDE
        2'b10:   m = SM_CONST_4;
        default: m = SM_CONST_8;
      endcase
    end else begin
      case (as_f)
        2'b00:   m = SM_REG;
        2'b01:   m = (rg == REG_PC) ? SM_SYMBOLIC : SM_INDEXED;
        2'b10:   m = SM_INDIRECT;
        default: m = (rg == REG_PC) ? SM_IMMEDIATE : SM_AUTOINC;  // @PC+ is #N
      endcase
    end
    return m;
  endfunction

  // ================================================
  // Operands per format
  // ================================================
  always_comb begin
    o_byte     = 1'b0;
    o_src_reg  = '0;        // Jump and IRQ carry no registers
    o_src_mode = SM_NONE;
    o_dst_reg  = '0;
    o_dst_mode = DM_NONE;
    case (i_class)
      IC_SINGLE: begin
        o_byte     = op[OP_BW_BIT];
        o_src_reg  = lo_reg;
        o_src_mode = src_mode_f(as_bits, lo_reg);
      end
      IC_TWO_OP: begin
        o_byte     = op[OP_BW_BIT];
        o_src_reg  = hi_reg;
        o_src_mode = src_mode_f(as_bits, hi_reg);
        o_dst_reg  = lo_reg;
        if (!op[OP_AD_BIT])       o_dst_mode = DM_REG;
        else if (lo_reg == REG_SR) o_dst_mode = DM_ABSOLUTE;
        else if (lo_reg == REG_PC) o_dst_mode = DM_SYMBOLIC;
        else                       o_dst_mode = DM_INDEXED;
      end
      default: ;
    endcase
  end

  // Exact opcode match, never on an interrupt entry
  always_comb begin
    if (i_held.irq)                 o_special = SP_NONE;
    else if (op == NOP_OPCODE)      o_special = SP_NOP;
    else if (op == SWBRK_OPCODE)    o_special = SP_SBREAK;
    else                            o_special = SP_NONE;
  end

endmodule

`default_nettype wire

//--- design/state_decode.sv
/*
 * State decoder
 * Names the fetch and execute FSM state codes of the followed core
 */

`timescale 1ns/1ps
`default_nettype none

module state_decode
  import trace_pkg::*;
(
  input  wire          mclk,
  input  wire          puc_rst,
  input  wire  [2:0]   i_fetch_bin,
  input  wire  [3:0]   i_exec_bin,
  output fetch_state_e o_fetch_state,
  output exec_state_e  o_exec_state
);

  // Fetch FSM
  always_comb begin
    case (i_fetch_bin)
      3'h0:    o_fetch_state = FS_IRQ_FETCH;
      3'h1:    o_fetch_state = FS_IRQ_DONE;
      3'h2:    o_fetch_state = FS_DEC;
      3'h3:    o_fetch_state = FS_EXT1;
      3'h4:    o_fetch_state = FS_EXT2;
      3'h5:    o_fetch_state = FS_IDLE;
      default: o_fetch_state = FS_INVALID;
    endcase
  end

  // Execute FSM, IRQ steps are not in code order
  always_comb begin
    case (i_exec_bin)
      4'h2:    o_exec_state = ES_IRQ_0;
      4'h1:    o_exec_state = ES_IRQ_1;
      4'h0:    o_exec_state = ES_IRQ_2;
      4'h3:    o_exec_state = ES_IRQ_3;
      4'h4:    o_exec_state = ES_IRQ_4;
      4'h5:    o_exec_state = ES_SRC_AD;
      4'h6:    o_exec_state = ES_SRC_RD;
      4'h7:    o_exec_state = ES_SRC_WR;
      4'h8:    o_exec_state = ES_DST_AD;
      4'h9:    o_exec_state = ES_DST_RD;
      4'hA:    o_exec_state = ES_DST_WR;
      4'hB:    o_exec_state = ES_EXEC;
      4'hC:    o_exec_state = ES_JUMP;
      4'hD:    o_exec_state = ES_IDLE;
      default: o_exec_state = ES_INVALID;
    endcase
  end

  a_exec_known: assert property (
    @(posedge mclk) disable iff (puc_rst) !$isunknown(i_exec_bin)
  ) else $error("execute state code unknown");

endmodule

`default_nettype wire

//--- design/trace_monitor.sv
/*
 * Dual-core MSP430 trace monitor
 * Follows the selected core and reports the current instruction,
 * its PC, counters and the named FSM states
 */

`timescale 1ns/1ps
`default_nettype none

module trace_monitor
  import msp430_isa_pkg::*, trace_pkg::*;
#(
  parameter int CNT_W = 32  // Instruction and cycle counters
) (
  input  wire              mclk,
  input  wire              puc_rst,
  input  wire core_trace_t i_core0,
  input  wire core_trace_t i_core1,
  input  wire              i_core_select,
  output inst_record_t     o_record,
  output logic [15:0]      o_inst_pc,
  output logic [CNT_W-1:0] o_inst_number,
  output logic [CNT_W-1:0] o_inst_cycle,
  output fetch_state_e     o_fetch_state,
  output exec_state_e      o_exec_state
);

  held_inst_t           held;
  inst_class_e          inst_class;
  mnemonic_e            mnemonic;
  logic                 byte_mode;
  logic [REG_IDX_W-1:0] src_reg;
  logic [REG_IDX_W-1:0] dst_reg;
  src_mode_e            src_mode;
  dst_mode_e            dst_mode;
  special_e             special;
  logic [2:0]           fetch_bin;
  logic [3:0]           exec_bin;

  inst_capture #(.CNT_W(CNT_W)) u_capture (
    .mclk, .puc_rst, .i_core0, .i_core1, .i_core_select,
    .o_held(held), .o_inst_pc, .o_inst_number, .o_inst_cycle,
    .o_fetch_bin(fetch_bin), .o_exec_bin(exec_bin)
  );

  inst_classify u_classify (.i_held(held), .o_class(inst_class), .o_mnemonic(mnemonic));

  operand_decode u_operands (
    .i_held(held), .i_class(inst_class), .o_byte(byte_mode),
    .o_src_reg(src_reg), .o_src_mode(src_mode),
    .o_dst_reg(dst_reg), .o_dst_mode(dst_mode), .o_special(special)
  );

  state_decode u_states (
    .mclk, .puc_rst, .i_fetch_bin(fetch_bin), .i_exec_bin(exec_bin),
    .o_fetch_state, .o_exec_state
  );

  // Combinational from held value, valid right after the capture edge
  assign o_record = '{inst_class: inst_class, mnemonic: mnemonic,
                      irq_num: held.irq_num, byte_mode: byte_mode,
                      src_reg: src_reg, src_mode: src_mode,
                      dst_reg: dst_reg, dst_mode: dst_mode, special: special};

endmodule

`default_nettype wire

//--- design/trace_pkg.sv
/*
 * Trace monitor types
 * Live trace of one core, named fetch and execute states,
 * the captured instruction and the decoded instruction record
 */

`default_nettype none

package trace_pkg;

  import msp430_isa_pkg::*;

  // Trace signals of one core, sampled on mclk
  typedef struct packed {
    logic [2:0]           fetch_bin;   // Fetch FSM state code
    logic [3:0]           exec_bin;    // Execute FSM state code
    logic                 decode;      // One-cycle decode strobe
    logic [OPCODE_W-1:0]  ir;          // Instruction register
    logic                 irq_detect;  // Interrupt being taken
    logic [IRQ_NUM_W-1:0] irq_num;
    logic [15:0]          pc;
  } core_trace_t;

  typedef enum logic [2:0] {
    FS_IRQ_FETCH, FS_IRQ_DONE, FS_DEC, FS_EXT1, FS_EXT2, FS_IDLE,
    FS_INVALID  // Codes 6, 7
  } fetch_state_e;

  typedef enum logic [3:0] {
    ES_IRQ_0, ES_IRQ_1, ES_IRQ_2, ES_IRQ_3, ES_IRQ_4,
    ES_SRC_AD, ES_SRC_RD, ES_SRC_WR,
    ES_DST_AD, ES_DST_RD, ES_DST_WR,
    ES_EXEC, ES_JUMP, ES_IDLE,
    ES_INVALID  // Codes E, F
  } exec_state_e;

  // Held on decode, 21 bits
  typedef struct packed {
    logic [OPCODE_W-1:0]  opcode;
    logic                 irq;      // Entry is an interrupt
    logic [IRQ_NUM_W-1:0] irq_num;
  } held_inst_t;

  typedef struct packed {
    inst_class_e          inst_class;
    mnemonic_e            mnemonic;
    logic [IRQ_NUM_W-1:0] irq_num;
    logic                 byte_mode;  // .B suffix
    logic [REG_IDX_W-1:0] src_reg;
    src_mode_e            src_mode;
    logic [REG_IDX_W-1:0] dst_reg;
    dst_mode_e            dst_mode;
    special_e             special;
  } inst_record_t;

endpackage

`default_nettype wire

//--- project.f
design/msp430_isa_pkg.sv
design/trace_pkg.sv
design/inst_capture.sv
design/inst_classify.sv
design/operand_decode.sv
design/state_decode.sv
design/trace_monitor.sv
tests/trace_monitor_tb.sv

//--- tests/trace_monitor_tb.sv
/*
 * Testbench for the dual-core trace monitor
 * Two random core traces drive the DUT, a behavioural model follows the
 * selected core and a reference decoder predicts every output
 */

`timescale 1ns/1ps
`default_nettype none

module trace_monitor_tb
  import msp430_isa_pkg::*, trace_pkg::*;
;

  // ==================================================
  // Run setup
  // ==================================================
  localparam int CLK_PERIOD    = 40;
  localparam int CNT_W         = 32;
  localparam int NUM_TESTS     = 6;
  localparam int VECS_PER_TEST = 200;  // Upper bound on cycles per test

  logic               mclk;
  logic               puc_rst;
  logic               i_core_select;
  core_trace_t        i_core0;
  core_trace_t        i_core1;
  inst_record_t       o_record;
  logic [15:0]        o_inst_pc;
  logic [CNT_W-1:0]   o_inst_number;
  logic [CNT_W-1:0]   o_inst_cycle;
  fetch_state_e       o_fetch_state;
  exec_state_e        o_exec_state;

  integer seed = 32'h843e441d;
  int     checks;
  int     errors;
  int     test_no;
  int     base_checks;   // Counts at start of current test
  int     base_errors;
  bit     check_en;      // Compare only once out of reset

  // Model of the held state, updated on each rising edge
  held_inst_t       exp_held = '{opcode: 16'h0000, irq: 1'b1, irq_num: 4'hF};
  logic [15:0]      exp_pc;
  logic [CNT_W-1:0] exp_num;
  logic [CNT_W-1:0] exp_cycle;

  logic [3:0] src_regs [4] = '{4'd0, 4'd2, 4'd3, 4'd7};  // PC, SR/CG1, CG2, plain

  trace_monitor #(.CNT_W(CNT_W)) i_trace_monitor (
    .mclk, .puc_rst, .i_core0, .i_core1, .i_core_select,
    .o_record, .o_inst_pc, .o_inst_number, .o_inst_cycle,
    .o_fetch_state, .o_exec_state
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  // ==================================================
  // Reference decoder
  // ==================================================
  function automatic src_mode_e src_mode_of(input logic [3:0] r, input logic [1:0] as_v);
    src_mode_e m;
    if (r == 4'd3) begin  // Constant generator 2
      m = (as_v == 2'd0) ? SM_CONST_0 : (as_v == 2'd1) ? SM_CONST_1 :
          (as_v == 2'd2) ? SM_CONST_2 : SM_CONST_M1;
    end else if (r == 4'd2) begin
      m = (as_v == 2'd0) ? SM_REG : (as_v == 2'd1) ? SM_ABSOLUTE :
          (as_v == 2'd2) ? SM_CONST_4 : SM_CONST_8;
    end else if (r == 4'd0) begin
      m = (as_v == 2'd0) ? SM_REG : (as_v == 2'd1) ? SM_SYMBOLIC :
          (as_v == 2'd2) ? SM_INDIRECT : SM_IMMEDIATE;
    end else begin
      m = (as_v == 2'd0) ? SM_REG : (as_v == 2'd1) ? SM_INDEXED :
          (as_v == 2'd2) ? SM_INDIRECT : SM_AUTOINC;
    end
    return m;
  endfunction

  function automatic inst_record_t expected_record(input held_inst_t h);
    inst_record_t r;
    logic [15:0]  op;
    logic [4:0]   idx;  // Position in mnemonic list
    op          = h.opcode;
    r.inst_class = IC_IRQ;
    r.mnemonic  = MN_INVALID;
    r.irq_num   = h.irq_num;
    r.byte_mode = 1'b0;
    r.src_reg   = 4'd0;
    r.src_mode  = SM_NONE;
    r.dst_reg   = 4'd0;
    r.dst_mode  = DM_NONE;
    r.special   = SP_NONE;
    if (h.irq) begin
      r.mnemonic = (h.irq_num == 4'd15) ? MN_RESET :
                   (h.irq_num == 4'd14) ? MN_NMI : MN_IRQ;
    end else if (op[15:13] == 3'b000) begin
      r.inst_class = IC_SINGLE;
      if (op[15:10] == 6'b000100 && op[9:7] != 3'b111) begin
        idx        = 5'(MN_RRC) + {2'b00, op[9:7]};  // RRC..RETI in order
        r.mnemonic = mnemonic_e'(idx);
      end
      r.byte_mode = op[6];
      r.src_reg   = op[3:0];
      r.src_mode  = src_mode_of(op[3:0], op[5:4]);
    end else if (op[15:13] == 3'b001) begin
      r.inst_class = IC_JUMP;
      idx          = 5'(MN_JNE) + {2'b00, op[12:10]};
      r.mnemonic   = mnemonic_e'(idx);
    end else begin
      r.inst_class = IC_TWO_OP;
      idx          = 5'(MN_MOV) + {1'b0, op[15:12]} - 5'd4;  // MOV is 0100
      r.mnemonic   = mnemonic_e'(idx);
      r.byte_mode  = op[6];
      r.src_reg    = op[11:8];
      r.src_mode   = src_mode_of(op[11:8], op[5:4]);
      r.dst_reg    = op[3:0];
      if (!op[7])                r.dst_mode = DM_REG;
      else if (op[3:0] == 4'd2)  r.dst_mode = DM_ABSOLUTE;
      else if (op[3:0] == 4'd0)  r.dst_mode = DM_SYMBOLIC;
      else                       r.dst_mode = DM_INDEXED;
    end
    if (!h.irq && op == 16'h4303) r.special = SP_NOP;
    if (!h.irq && op == 16'h4343) r.special = SP_SBREAK;
    return r;
  endfunction

  function automatic fetch_state_e fetch_name(input logic [2:0] c);
    return (c < 3'd6) ? fetch_state_e'(c) : FS_INVALID;
  endfunction

  // Codes 2,1,0 are IRQ_0..IRQ_2, rest follow code order
  function automatic exec_state_e exec_name(input logic [3:0] c);
    if (c <= 4'd2)  return exec_state_e'(4'd2 - c);
    if (c <= 4'hD)  return exec_state_e'(c);
    return ES_INVALID;
  endfunction

  // ==================================================
  // Stimulus helpers
  // ==================================================
  function automatic core_trace_t rand_trace(input logic dec);
    core_trace_t t;
    t.fetch_bin  = 3'($random(seed));
    t.exec_bin   = 4'($random(seed));
    t.decode     = dec;
    t.ir         = 16'($random(seed));
    t.irq_detect = 1'($random(seed));
    t.irq_num    = 4'($random(seed));
    t.pc         = 16'($random(seed));
    return t;
  endfunction

  // Trace with a decode strobe and a chosen instruction
  function automatic core_trace_t inst_trace(input logic [15:0] ir, input logic irq);
    core_trace_t t;
    t            = rand_trace(1'b1);
    t.ir         = ir;
    t.irq_detect = irq;
    return t;
  endfunction

  task automatic drive(input core_trace_t c0, input core_trace_t c1, input logic sel);
    @(posedge mclk);
    #2;
    i_core0       = c0;
    i_core1       = c1;
    i_core_select = sel;
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Waits out the last capture before printing the test line
  task automatic report_test(input string name);
    @(posedge mclk);
    @(negedge mclk);
    #1;
    test_no++;
    $display("Test %0d %-16s checks %0d, errors %0d", test_no, name,
             checks - base_checks, errors - base_errors);
    base_checks = checks;
    base_errors = errors;
  endtask

  // ==================================================
  // Model and compare
  // ==================================================
  always @(posedge mclk) begin : model
    core_trace_t s;
    s = i_core_select ? i_core1 : i_core0;
    if (puc_rst) begin
      exp_held  = '{opcode: 16'h0000, irq: 1'b1, irq_num: 4'hF};  // Reads as RESET
      exp_pc    = '0;
      exp_num   = '0;
      exp_cycle = '0;
    end else if (s.decode) begin
      exp_held = '{opcode: s.ir, irq: s.irq_detect, irq_num: s.irq_num};
      exp_pc    = s.pc;
      exp_num   = exp_num + 1;
      exp_cycle = '0;
    end else begin
      exp_cycle = exp_cycle + 1;
    end
  end

  // Outputs settled half a period after the capture edge
  always @(negedge mclk) begin : compare
    inst_record_t e;
    core_trace_t  s;
    if (check_en) begin
      e = expected_record(exp_held);
      s = i_core_select ? i_core1 : i_core0;
      check_value("o_record.inst_class", o_record.inst_class, e.inst_class);
      check_value("o_record.mnemonic", o_record.mnemonic, e.mnemonic);
      check_value("o_record.irq_num", o_record.irq_num, e.irq_num);
      check_value("o_record.byte_mode", o_record.byte_mode, e.byte_mode);
      check_value("o_record.src_reg", o_record.src_reg, e.src_reg);
      check_value("o_record.src_mode", o_record.src_mode, e.src_mode);
      check_value("o_record.dst_reg", o_record.dst_reg, e.dst_reg);
      check_value("o_record.dst_mode", o_record.dst_mode, e.dst_mode);
      check_value("o_record.special", o_record.special, e.special);
      check_value("o_inst_pc", o_inst_pc, exp_pc);
      check_value("o_inst_number", o_inst_number, exp_num);
      check_value("o_inst_cycle", o_inst_cycle, exp_cycle);
      check_value("o_fetch_state", o_fetch_state, fetch_name(s.fetch_bin));
      check_value("o_exec_state", o_exec_state, exec_name(s.exec_bin));
    end
  end

  // Watchdog
  initial begin
    #((NUM_TESTS * VECS_PER_TEST + 100) * CLK_PERIOD);
    $display("Simulation timed out before all tests finished");
    $display("Done: errors found");
    $finish;
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    core_trace_t t0;
    core_trace_t t1;
    logic        sel_q;
    puc_rst       = 1'b1;
    i_core_select = 1'b0;
    i_core0       = '0;
    i_core1       = '0;
    check_en      = 1'b0;
    checks        = 0;
    errors        = 0;
    test_no       = 0;
    base_checks   = 0;
    base_errors   = 0;
    repeat (10) @(posedge mclk);
    #2;
    puc_rst  = 1'b0;
    check_en = 1'b1;

    // 1: reset values before any decode
    @(negedge mclk);
    #1;
    check_value("o_record.inst_class", o_record.inst_class, IC_IRQ);
    check_value("o_record.mnemonic", o_record.mnemonic, MN_RESET);
    check_value("o_inst_pc", o_inst_pc, 0);
    check_value("o_inst_number", o_inst_number, 0);
    check_value("o_inst_cycle", o_inst_cycle, 0);
    for (int k = 0; k < 5; k++) drive(rand_trace(1'b0), rand_trace(1'b0), 1'b0);
    report_test("after reset");

    // 2: random opcodes, NOP and SBREAK mixed in
    for (int k = 0; k < 150; k++) begin
      if (k % 25 == 5)       t0 = inst_trace(16'h4303, 1'b0);
      else if (k % 25 == 17) t0 = inst_trace(16'h4343, 1'b0);
      else                   t0 = rand_trace(1'($random(seed)));
      drive(t0, rand_trace(1'($random(seed))), 1'b0);
    end
    report_test("random decodes");

    // 3: source sweep in both formats, then dest, jump and IRQ
    for (int i = 0; i < 4; i++) begin
      for (int a = 0; a < 4; a++) begin
        t0 = inst_trace({6'b000100, 3'(i + a), 1'(a), 2'(a), src_regs[i]}, 1'b0);
        drive(t0, rand_trace(1'b0), 1'b0);
        t0 = inst_trace({4'(4 + i + a), src_regs[i], 1'(i), 1'(a), 2'(a),
                         4'($random(seed))}, 1'b0);
        drive(t0, rand_trace(1'b0), 1'b0);
      end
    end
    for (int d = 0; d < 16; d++) begin
      for (int ad = 0; ad < 2; ad++) begin
        t0 = inst_trace({4'(4 + d % 12), 4'($random(seed)), 1'(ad), 1'(d), 2'(d), 4'(d)},
                        1'b0);
        drive(t0, rand_trace(1'b0), 1'b0);
      end
    end
    for (int j = 0; j < 8; j++) begin
      drive(inst_trace({3'b001, 3'(j), 10'($random(seed))}, 1'b0), rand_trace(1'b0), 1'b0);
      drive(inst_trace(16'($random(seed)), 1'b1), rand_trace(1'b0), 1'b0);
    end
    report_test("addressing modes");

    // 4: sparse and back-to-back strobes
    for (int k = 0; k < 150; k++) begin
      drive(rand_trace(1'($random(seed))), rand_trace(1'b0), 1'b0);
    end
    report_test("counters");

    // 5: select flips after every taken decode
    sel_q = 1'b0;
    for (int k = 0; k < 120; k++) begin
      t0 = rand_trace(1'($random(seed)));
      t1 = rand_trace(1'($random(seed)));
      drive(t0, t1, sel_q);
      if (sel_q ? t1.decode : t0.decode) sel_q = ~sel_q;
    end
    report_test("core selection");

    // 6: every fetch and execute code, alternating cores
    for (int f = 0; f < 8; f++) begin
      for (int e = 0; e < 16; e++) begin
        t0           = rand_trace(1'b0);
        t0.fetch_bin = 3'(f);
        t0.exec_bin  = 4'(e);
        t1           = rand_trace(1'b0);
        if (f % 2 == 1) drive(t1, t0, 1'b1);
        else            drive(t0, t1, 1'b0);
      end
    end
    report_test("state decode");

    $display("Total: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
